/* verilog/pcie_rd_pkg.sv */
`default_nettype none

package pcie_rd_pkg;

    // Address bus, dword granular from bit 2 up
    localparam int ADDR_W = 32;

    // AXI length field, transfers are len + 1 dwords
    localparam int AXI_LEN_W = 4;

    // TLP length field, a value of 0 stands for 1024 dwords
    localparam int TLP_LEN_W = 10;
    localparam int LEN_CNT_W = TLP_LEN_W + 1;

    // Max Read Request code, 0 to 5 for 128 to 4096 bytes
    localparam int MRR_CODE_W = 3;
    localparam logic [MRR_CODE_W-1:0] MRR_CODE_MAX = 3'd5;
    localparam int MRR_MIN_DW = 32;

    // Idle cycles the merge stage waits after each accepted command
    localparam int MERGE_WINDOW = 4;
    localparam int MERGE_WIN_W = $clog2(MERGE_WINDOW + 1);

    // 4 KB page in dwords
    localparam int PAGE_DW = 1024;
    localparam int PAGE_OFS_W = $clog2(PAGE_DW);
    localparam int PAGE_LSB = PAGE_OFS_W + 2;

    // Request size in dwords for a Max Read Request code
    function automatic logic [LEN_CNT_W-1:0] mrr_dwords(input logic [MRR_CODE_W-1:0] code);
        logic [MRR_CODE_W-1:0] code_sat;
        code_sat = (code > MRR_CODE_MAX) ? MRR_CODE_MAX : code;
        return LEN_CNT_W'(MRR_MIN_DW) << code_sat;
    endfunction

endpackage

`default_nettype wire

/* verilog/rd_csr_pkg.sv */
`default_nettype none

package rd_csr_pkg;

    // Wishbone data path and decoded byte address bits
    localparam int CSR_ADDR_W = 4;
    localparam int CSR_DATA_W = 32;
    localparam int CSR_SEL_W = CSR_DATA_W / 8;

    // Register offsets
    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL = 4'h0;
    localparam logic [CSR_ADDR_W-1:0] CSR_CMD_CNT = 4'h4;
    localparam logic [CSR_ADDR_W-1:0] CSR_TLP_CNT = 4'h8;

    // CTRL fields
    localparam int CTRL_MRR_LSB = 0;
    localparam int CTRL_MRR_MSB = 2;
    localparam int CTRL_MERGE_BIT = 4;

    // CTRL reset values
    localparam logic [CTRL_MRR_MSB-CTRL_MRR_LSB:0] CTRL_MRR_RST = '0;
    localparam logic CTRL_MERGE_RST = 1'b0;

endpackage

`default_nettype wire

/* verilog/rd_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Read request of a start address and a dword length
interface rd_cmd_if import pcie_rd_pkg::*; ();

    logic                 valid;
    logic                 ready;
    logic [ADDR_W-1:2]    addr;
    // 1 to 1024 dwords, 1024 encoded as 0
    logic [TLP_LEN_W-1:0] len;

    modport src (
        output valid,
        input  ready,
        output addr,
        output len
    );

    modport dst (
        input  valid,
        output ready,
        input  addr,
        input  len
    );

endinterface

`default_nettype wire

/* verilog/rd_req_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_req_merge import pcie_rd_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 merge_en,
    input  wire                 axi_ar_valid,
    output logic                axi_ar_ready,
    input  wire [ADDR_W-1:2]    axi_ar_addr,
    input  wire [AXI_LEN_W-1:0] axi_ar_len,
    rd_cmd_if.src               cmd
);

    logic                    held;
    logic                    held_rel;
    logic [MERGE_WIN_W-1:0]  win_cnt;

    logic [ADDR_W-1:2]       held_addr;
    logic [TLP_LEN_W-1:0]    held_len;
    logic [PAGE_OFS_W-1:0]   held_end;

    logic [TLP_LEN_W-1:0]    axi_dw;
    logic                    can_merge;
    logic                    load;
    logic                    cmd_fire;

    // AXI length field to a dword count
    assign axi_dw = {{(TLP_LEN_W-AXI_LEN_W){1'b0}}, axi_ar_len} + TLP_LEN_W'(1);

    // Contiguous in the same page, and the held end is not a page boundary
    assign can_merge = merge_en && held && !held_rel && axi_ar_valid &&
                       (axi_ar_addr[ADDR_W-1:PAGE_LSB] == held_addr[ADDR_W-1:PAGE_LSB]) &&
                       (axi_ar_addr[PAGE_LSB-1:2] == held_end) &&
                       (held_end != '0);

    always_comb begin
        if (held) begin
            // Release on window expiry or when a non-mergeable command waits
            cmd.valid    = !can_merge &&
                           (held_rel || !merge_en || (win_cnt == '0) || axi_ar_valid);
            cmd.addr     = held_addr;
            cmd.len      = held_len;
            axi_ar_ready = can_merge;
        end else begin
            // Pass-through path when merging is off
            cmd.valid    = !merge_en && axi_ar_valid;
            cmd.addr     = axi_ar_addr;
            cmd.len      = axi_dw;
            axi_ar_ready = merge_en || cmd.ready;
        end
    end

    assign cmd_fire = cmd.valid && cmd.ready;

    // Commands go into the holding register only with merging on
    assign load = axi_ar_valid && axi_ar_ready && merge_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            held     <= 1'b0;
            held_rel <= 1'b0;
            win_cnt  <= '0;
        end else begin
            if (cmd_fire) begin
                held     <= 1'b0;
                held_rel <= 1'b0;
            end else if (held && cmd.valid) begin
                // Once offered, the request stays frozen until taken
                held_rel <= 1'b1;
            end
            if (load) begin
                held <= 1'b1;
            end

            if (load) begin
                win_cnt <= MERGE_WIN_W'(MERGE_WINDOW);
            end else if (win_cnt != '0) begin
                win_cnt <= win_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (held) begin
                held_len <= held_len + axi_dw;
                held_end <= held_end + axi_dw;
            end else begin
                held_addr <= axi_ar_addr;
                held_len  <= axi_dw;
                // Wraps to 0 when the command ends on a page boundary
                held_end  <= axi_ar_addr[PAGE_LSB-1:2] + axi_dw;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rd_req_split.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_req_split import pcie_rd_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [MRR_CODE_W-1:0] mrr_code,
    rd_cmd_if.dst                req,
    output logic                 tlp_h_valid,
    input  wire                  tlp_h_ready,
    output logic [ADDR_W-1:2]    tlp_h_addr,
    output logic [TLP_LEN_W-1:0] tlp_h_len
);

    // Progress of the request in flight
    logic [ADDR_W-1:2]    nxt_addr;
    logic [LEN_CNT_W-1:0] rem;
    logic [LEN_CNT_W-1:0] size_q;

    logic                 req_fire;
    logic                 hdr_adv;
    logic                 last_out;

    logic [LEN_CNT_W-1:0] req_cnt;
    logic [ADDR_W-1:2]    src_addr;
    logic [LEN_CNT_W-1:0] src_rem;
    logic [LEN_CNT_W-1:0] src_size;
    logic [LEN_CNT_W-1:0] src_ofs;
    logic [LEN_CNT_W-1:0] to_bound;
    logic [LEN_CNT_W-1:0] chunk;

    // Final header of the current request leaves this cycle
    assign last_out  = tlp_h_valid && tlp_h_ready && (rem == '0);

    assign req.ready = !tlp_h_valid || last_out;
    assign req_fire  = req.valid && req.ready;
    assign hdr_adv   = tlp_h_valid && tlp_h_ready && (rem != '0);

    // Length 0 on the interface means 1024
    assign req_cnt = {(req.len == '0), req.len};

    // Start a new request or continue the current one
    always_comb begin
        if (req_fire) begin
            src_addr = req.addr;
            src_rem  = req_cnt;
            src_size = mrr_dwords(mrr_code);
        end else begin
            src_addr = nxt_addr;
            src_rem  = rem;
            src_size = size_q;
        end
    end

    // Dwords up to the next size aligned boundary
    assign src_ofs  = {1'b0, src_addr[PAGE_LSB-1:2]} & (src_size - LEN_CNT_W'(1));
    assign to_bound = src_size - src_ofs;
    assign chunk    = (src_rem < to_bound) ? src_rem : to_bound;

    always_ff @(posedge clk) begin
        if (rst) begin
            tlp_h_valid <= 1'b0;
        end else if (req_fire) begin
            tlp_h_valid <= 1'b1;
        end else if (last_out) begin
            tlp_h_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire || hdr_adv) begin
            tlp_h_addr <= src_addr;
            // A full 1024 dword header encodes as 0
            tlp_h_len  <= chunk[TLP_LEN_W-1:0];
            nxt_addr   <= src_addr + (ADDR_W-2)'(chunk);
            rem        <= src_rem - chunk;
            size_q     <= src_size;
        end
    end

endmodule

`default_nettype wire

/* verilog/rd_req_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_req_csr import pcie_rd_pkg::*; import rd_csr_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   wb_cyc,
    input  wire                   wb_stb,
    input  wire                   wb_we,
    input  wire [CSR_ADDR_W-1:0]  wb_adr,
    input  wire [CSR_DATA_W-1:0]  wb_dat_w,
    input  wire [CSR_SEL_W-1:0]   wb_sel,
    output logic [CSR_DATA_W-1:0] wb_dat_r,
    output logic                  wb_ack,
    input  wire                   cmd_fire,
    input  wire                   tlp_fire,
    output logic [MRR_CODE_W-1:0] mrr_code,
    output logic                  merge_en
);

    logic                  wb_req;
    logic                  ctrl_wr;
    logic [MRR_CODE_W-1:0] wr_code;
    logic [CSR_DATA_W-1:0] ctrl_val;
    logic [CSR_DATA_W-1:0] rd_val;

    logic [CSR_DATA_W-1:0] cmd_cnt;
    logic [CSR_DATA_W-1:0] tlp_cnt;

    // New classic cycle seen while ack is still low
    assign wb_req  = wb_cyc && wb_stb && !wb_ack;

    // Control fields all sit in byte lane 0
    assign ctrl_wr = wb_req && wb_we && wb_sel[0] && (wb_adr == CSR_CTRL);

    assign wr_code = wb_dat_w[CTRL_MRR_MSB:CTRL_MRR_LSB];

    always_comb begin
        ctrl_val = '0;
        ctrl_val[CTRL_MRR_MSB:CTRL_MRR_LSB] = mrr_code;
        ctrl_val[CTRL_MERGE_BIT] = merge_en;
    end

    always_comb begin
        case (wb_adr)
            CSR_CTRL:    rd_val = ctrl_val;
            CSR_CMD_CNT: rd_val = cmd_cnt;
            CSR_TLP_CNT: rd_val = tlp_cnt;
            default:     rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            mrr_code <= CTRL_MRR_RST;
            merge_en <= CTRL_MERGE_RST;
        end else begin
            wb_ack <= wb_req;
            if (ctrl_wr) begin
                // Codes past 4096 bytes saturate
                mrr_code <= (wr_code > MRR_CODE_MAX) ? MRR_CODE_MAX : wr_code;
                merge_en <= wb_dat_w[CTRL_MERGE_BIT];
            end
        end
    end

    // Event counters wrap at 32 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_cnt <= '0;
            tlp_cnt <= '0;
        end else begin
            if (cmd_fire) begin
                cmd_cnt <= cmd_cnt + 1'b1;
            end
            if (tlp_fire) begin
                tlp_cnt <= tlp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_r <= rd_val;
        end
    end

endmodule

`default_nettype wire

/* verilog/pcie_rd_req_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcie_rd_req_top import pcie_rd_pkg::*; import rd_csr_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,

    // AXI read command
    input  wire                  axi_ar_valid,
    output wire                  axi_ar_ready,
    input  wire [ADDR_W-1:2]     axi_ar_addr,
    input  wire [AXI_LEN_W-1:0]  axi_ar_len,

    // TLP read header
    output wire                  tlp_h_valid,
    input  wire                  tlp_h_ready,
    output wire [ADDR_W-1:2]     tlp_h_addr,
    output wire [TLP_LEN_W-1:0]  tlp_h_len,

    // Wishbone classic slave
    input  wire                  wb_cyc,
    input  wire                  wb_stb,
    input  wire                  wb_we,
    input  wire [CSR_ADDR_W-1:0] wb_adr,
    input  wire [CSR_DATA_W-1:0] wb_dat_w,
    input  wire [CSR_SEL_W-1:0]  wb_sel,
    output wire [CSR_DATA_W-1:0] wb_dat_r,
    output wire                  wb_ack
);

    wire [MRR_CODE_W-1:0] mrr_code;
    wire                  merge_en;
    wire                  cmd_fire;
    wire                  tlp_fire;

    // Event strobes for the counters
    assign cmd_fire = axi_ar_valid && axi_ar_ready;
    assign tlp_fire = tlp_h_valid && tlp_h_ready;

    rd_cmd_if cmd_if ();

    rd_req_merge i_merge (
        .clk          (clk),
        .rst          (rst),
        .merge_en     (merge_en),
        .axi_ar_valid (axi_ar_valid),
        .axi_ar_ready (axi_ar_ready),
        .axi_ar_addr  (axi_ar_addr),
        .axi_ar_len   (axi_ar_len),
        .cmd          (cmd_if.src)
    );

    rd_req_split i_split (
        .clk         (clk),
        .rst         (rst),
        .mrr_code    (mrr_code),
        .req         (cmd_if.dst),
        .tlp_h_valid (tlp_h_valid),
        .tlp_h_ready (tlp_h_ready),
        .tlp_h_addr  (tlp_h_addr),
        .tlp_h_len   (tlp_h_len)
    );

    rd_req_csr i_csr (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cmd_fire (cmd_fire),
        .tlp_fire (tlp_fire),
        .mrr_code (mrr_code),
        .merge_en (merge_en)
    );

endmodule

`default_nettype wire

/* verif/tb_pcie_rd_req.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_rd_req import pcie_rd_pkg::*; import rd_csr_pkg::*; ();

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  axi_ar_valid;
    logic                  axi_ar_ready;
    logic [ADDR_W-1:2]     axi_ar_addr;
    logic [AXI_LEN_W-1:0]  axi_ar_len;
    logic                  tlp_h_valid;
    logic                  tlp_h_ready;
    logic [ADDR_W-1:2]     tlp_h_addr;
    logic [TLP_LEN_W-1:0]  tlp_h_len;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [CSR_ADDR_W-1:0] wb_adr;
    logic [CSR_DATA_W-1:0] wb_dat_w;
    logic [CSR_SEL_W-1:0]  wb_sel;
    logic [CSR_DATA_W-1:0] wb_dat_r;
    logic                  wb_ack;

    integer            seed = 32'h908b_9d00;
    int                mismatch_cnt;
    int                fail_cnt;
    int                ack_cnt;
    int                axi_hs_cnt;
    int                tlp_hs_cnt;
    int                stim_dw;
    int                rcv_dw;
    int                mrr_sz;
    int                hdr_dw;
    int                hdr_ofs;
    logic              merge_on;
    logic              bp_on;
    // Requested dword ranges, with the request size in force when each began
    logic [ADDR_W-1:2] rng_addr[$];
    int                rng_len[$];
    int                rng_size[$];
    // Observed headers
    logic [ADDR_W-1:2] hdr_addr_q[$];
    int                hdr_len_q[$];

    pcie_rd_req_top i_dut (.*);

    always #5 clk = ~clk;

    always_comb begin
        hdr_dw  = (tlp_h_len == '0) ? PAGE_DW : int'(tlp_h_len);
        hdr_ofs = int'(tlp_h_addr[PAGE_LSB-1:2]);
    end

    assert property (@(posedge clk) disable iff (rst)
        tlp_h_valid && !tlp_h_ready |=> tlp_h_valid && $stable(tlp_h_addr) && $stable(tlp_h_len))
        else begin
            $display("ERROR: TLP header changed while stalled at %0t", $time);
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (rst) tlp_h_valid |-> hdr_ofs + hdr_dw <= PAGE_DW)
        else begin
            $display("ERROR: TLP header at %0t crosses a 4 KB page", $time);
            fail_cnt++;
        end

    // No header runs past the next multiple of the request size
    assert property (@(posedge clk) disable iff (rst)
        tlp_h_valid |-> (hdr_ofs % mrr_sz) + hdr_dw <= mrr_sz)
        else begin
            $display("ERROR: TLP header at %0t crosses a Max Read Request boundary", $time);
            fail_cnt++;
        end

    // Handshakes are sampled mid cycle where all signals have settled
    always @(negedge clk) begin : monitor
        int                n;
        logic [ADDR_W-1:2] end_addr;
        if (wb_ack) ack_cnt++;
        if (!rst && axi_ar_valid && axi_ar_ready) begin
            axi_hs_cnt++;
            n        = rng_addr.size();
            end_addr = (n > 0) ? rng_addr[n-1] + (ADDR_W-2)'(rng_len[n-1]) : '0;
            // Contiguous joins the last range unless that range ends on a page boundary
            if (merge_on && n > 0 && axi_ar_addr == end_addr &&
                end_addr[PAGE_LSB-1:2] != '0) begin
                rng_len[n-1] += int'(axi_ar_len) + 1;
            end else begin
                rng_addr.push_back(axi_ar_addr);
                rng_len.push_back(int'(axi_ar_len) + 1);
                rng_size.push_back(mrr_sz);
            end
        end
        if (!rst && tlp_h_valid && tlp_h_ready) begin
            tlp_hs_cnt++;
            rcv_dw += hdr_dw;
            hdr_addr_q.push_back(tlp_h_addr);
            hdr_len_q.push_back(hdr_dw);
        end
    end

    initial begin : stall_driver
        tlp_h_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            tlp_h_ready = !bp_on || (($random(seed) & 1) == 1);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        mismatch_cnt++;
    endtask

    task automatic wb_access(input logic we, input logic [CSR_ADDR_W-1:0] adr,
                             input logic [CSR_DATA_W-1:0] wdat,
                             output logic [CSR_DATA_W-1:0] rdat);
        int acks;
        acks     = ack_cnt;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do @(negedge clk); while (!wb_ack);
        rdat = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        assert (ack_cnt == acks + 1) else begin
            $display("ERROR: access to 0x%0h got %0d acknowledges", adr, ack_cnt - acks);
            fail_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input logic [CSR_ADDR_W-1:0] adr,
                             input logic [CSR_DATA_W-1:0] exp);
        logic [CSR_DATA_W-1:0] rdat;
        wb_access(1'b0, adr, '0, rdat);
        assert (rdat == exp) else report_mismatch(name, exp, rdat);
    endtask

    task automatic set_ctrl(input int code, input logic merge);
        logic [CSR_DATA_W-1:0] wdat;
        logic [CSR_DATA_W-1:0] rdat;
        int                    sat;
        sat  = (code > 5) ? 5 : code;
        wdat = '0;
        wdat[CTRL_MRR_MSB:CTRL_MRR_LSB] = 3'(code);
        wdat[CTRL_MERGE_BIT] = merge;
        wb_access(1'b1, CSR_CTRL, wdat, rdat);
        merge_on = merge;
        // Code 0 is 128 bytes, each step doubles
        mrr_sz   = 32 << sat;
        wdat[CTRL_MRR_MSB:CTRL_MRR_LSB] = 3'(sat);
        check_reg($sformatf("ctrl code %0d", code), CSR_CTRL, wdat);
    endtask

    // Walk the headers through the requested ranges by the split rule
    task automatic check_headers(input string name);
        int exp_len;
        while (hdr_addr_q.size() > 0 && rng_addr.size() > 0) begin
            exp_len = rng_size[0] - int'(rng_addr[0]) % rng_size[0];
            if (rng_len[0] < exp_len) exp_len = rng_len[0];
            assert (hdr_addr_q[0] == rng_addr[0])
                else report_mismatch({name, " addr"}, rng_addr[0], hdr_addr_q[0]);
            assert (hdr_len_q[0] == exp_len)
                else report_mismatch({name, " len"}, exp_len, hdr_len_q[0]);
            rng_addr[0] = rng_addr[0] + (ADDR_W-2)'(exp_len);
            rng_len[0]  = rng_len[0] - exp_len;
            if (rng_len[0] == 0) begin
                void'(rng_addr.pop_front());
                void'(rng_len.pop_front());
                void'(rng_size.pop_front());
            end
            void'(hdr_addr_q.pop_front());
            void'(hdr_len_q.pop_front());
        end
        assert (hdr_addr_q.size() == 0 && rng_addr.size() == 0) else begin
            $display("ERROR: %s left %0d headers and %0d requested ranges unmatched",
                     name, hdr_addr_q.size(), rng_addr.size());
            fail_cnt++;
        end
    endtask

    task automatic run_phase(input string name, input int n_cmd, input logic contig);
        logic [ADDR_W-1:2] addr;
        int                dw;
        int                ofs;
        addr = '0;
        for (int i = 0; i < n_cmd; i++) begin
            // Jumps land in the last quarter of a page so streaks reach its end
            if (i == 0 || !contig || ($random(seed) & 7) == 0) begin
                ofs  = PAGE_DW - 1 - int'($unsigned($random(seed)) % 256);
                addr = (ADDR_W-2)'(int'($unsigned($random(seed)) % 8) * PAGE_DW + ofs);
            end
            dw  = int'($unsigned($random(seed)) % 16) + 1;
            ofs = int'(addr[PAGE_LSB-1:2]);
            // AXI bursts stay inside one 4 KB page
            if (ofs + dw > PAGE_DW) dw = PAGE_DW - ofs;
            stim_dw     += dw;
            axi_ar_valid = 1'b1;
            axi_ar_addr  = addr;
            axi_ar_len   = AXI_LEN_W'(dw - 1);
            do @(negedge clk); while (!axi_ar_ready);
            @(posedge clk);
            #1;
            axi_ar_valid = 1'b0;
            addr         = addr + (ADDR_W-2)'(dw);
            // Gaps stay shorter than the merge window
            repeat (int'($unsigned($random(seed)) % 3)) begin
                @(posedge clk);
                #1;
            end
        end
        while (rcv_dw < stim_dw) @(negedge clk);
        @(posedge clk);
        #1;
        check_headers(name);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < stim_dw * 40 + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        axi_ar_valid = 1'b0;
        axi_ar_addr  = '0;
        axi_ar_len   = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = '1;
        merge_on     = 1'b0;
        bp_on        = 1'b0;
        mrr_sz       = 32;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (tlp_h_valid == 1'b0) else report_mismatch("reset tlp_h_valid", 0, tlp_h_valid);
        assert (wb_ack == 1'b0) else report_mismatch("reset wb_ack", 0, wb_ack);
        assert (axi_ar_ready == 1'b1) else report_mismatch("reset axi_ar_ready", 1, axi_ar_ready);
        check_reg("reset ctrl", CSR_CTRL, '0);
        check_reg("reset cmd count", CSR_CMD_CNT, '0);
        check_reg("reset tlp count", CSR_TLP_CNT, '0);
        check_reg("unmapped 0xc", 4'hc, '0);
        check_reg("unmapped 0x2", 4'h2, '0);
        for (int c = 7; c >= 0; c--) set_ctrl(c, c[0]);

        for (int c = 0; c < 6; c++) begin
            set_ctrl(c, 1'b0);
            run_phase($sformatf("split code %0d", c), 25, 1'b0);
        end
        set_ctrl(2, 1'b1);
        run_phase("merge code 2", 150, 1'b1);
        set_ctrl(5, 1'b1);
        run_phase("merge code 5", 150, 1'b1);

        // Stalls on the header port, merge off and on
        bp_on = 1'b1;
        set_ctrl(1, 1'b0);
        run_phase("stall split", 60, 1'b0);
        set_ctrl(3, 1'b1);
        run_phase("stall merge", 150, 1'b1);
        bp_on = 1'b0;

        check_reg("cmd count", CSR_CMD_CNT, axi_hs_cnt);
        check_reg("tlp count", CSR_TLP_CNT, tlp_hs_cnt);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/pcie_rd_pkg.sv
verilog/rd_csr_pkg.sv
verilog/rd_cmd_if.sv
verilog/rd_req_merge.sv
verilog/rd_req_split.sv
verilog/rd_req_csr.sv
verilog/pcie_rd_req_top.sv
verif/tb_pcie_rd_req.sv
